/* verilog.f */
common/gat_cfg_pkg.sv
common/gat_dbg_pkg.sv
src/credit_fifo.sv
src/gat_ctrl.sv
dmvm/dmvm_stage.sv
aggr/aggr_stage.sv
src/gat_debugger.sv
src/gat_top.sv
test/gat_tb.sv

/* Makefile */
TOP = gat_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /TEST RESULT: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* test/gat_tb.sv */
`timescale 1ns/1ps

module gat_tb
  import gat_cfg_pkg::*;
  import gat_dbg_pkg::*;
;

  localparam int NUM_RECS       = 12;
  localparam int NUM_GROUPS     = 4;
  localparam int WITHHOLD_LEN   = 40;
  localparam int TIMEOUT_CYCLES = NUM_RECS * 20 + 200;

  logic        clk;
  logic        rst_n;
  logic        in_vld_i;
  feat_vec_t   in_feat_i;
  logic        in_last_i;
  logic        in_credit_o;
  logic        out_vld_o;
  sum_t        out_sum_o;
  logic        out_credit_i = 1'b0;
  logic [31:0] dbg_status_o;
  logic [31:0] dbg_count_o;
  logic [31:0] dbg_capture_o;

  // stimulus table with its expected columns
  feat_vec_t rec_feat  [NUM_RECS];
  logic      rec_last  [NUM_RECS];
  score_t    exp_score [NUM_RECS];
  sum_t      exp_sum   [NUM_GROUPS];

  int cycle_cnt     = 0;
  int pushed        = 0;                         // records driven by the source
  int credit_rx     = 0;                         // in_credit_o pulses seen
  int out_rx        = 0;                         // group sums seen
  int returned      = 0;                         // credits granted back by the sink
  int withhold_left = 0;
  bit withhold_done = 1'b0;
  int stall_cycles  = 0;

  gat_top gat_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_vld_i      (in_vld_i),
    .in_feat_i     (in_feat_i),
    .in_last_i     (in_last_i),
    .in_credit_o   (in_credit_o),
    .out_vld_o     (out_vld_o),
    .out_sum_o     (out_sum_o),
    .out_credit_i  (out_credit_i),
    .dbg_status_o  (dbg_status_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // checks and reference model

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("TEST RESULT: FAIL");
      $display("ERR %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, actual, expected);
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // dot product with the attention weights, negative side scaled down
  function automatic score_t expected_score(input feat_vec_t feat);
    int dot;
    dot = 0;
    for (int k = 0; k < VEC_LEN; k++) begin
      dot = dot + int'(feat[k]) * int'(ATT_WEIGHT[k]);
    end
    if (dot < 0) dot = dot >>> LEAKY_SHIFT;
    return score_t'(dot);
  endfunction

  task automatic set_rec(input int idx, input int e0, input int e1, input int e2,
                         input int e3, input logic last);
    rec_feat[idx][0] = feat_t'(e0);
    rec_feat[idx][1] = feat_t'(e1);
    rec_feat[idx][2] = feat_t'(e2);
    rec_feat[idx][3] = feat_t'(e3);
    rec_last[idx]    = last;
  endtask

  task automatic fill_table();
    sum_t acc;
    int   grp;
    set_rec(0,    10,    4,    2,   -7, 1'b0);
    set_rec(1,   -20,   15,   -3,    8, 1'b1);
    set_rec(2,   127, -128,  127,  127, 1'b0);
    set_rec(3,  -128,  127, -128, -128, 1'b0);
    set_rec(4,     0,    0,    0,    0, 1'b0);
    set_rec(5,     5,   30,   -6,    2, 1'b1);  // captured record, negative score
    set_rec(6,     1,    1,    1,    1, 1'b0);
    set_rec(7,    -1,   -1,   -1,   -1, 1'b0);
    set_rec(8,    40,  -10,   20, -100, 1'b1);
    set_rec(9,   -50,   60,  -70,   90, 1'b0);
    set_rec(10,    8,   -8,    8,   -8, 1'b0);
    set_rec(11,  100,  100, -100,    0, 1'b1);
    acc = '0;
    grp = 0;
    for (int i = 0; i < NUM_RECS; i++) begin
      exp_score[i] = expected_score(rec_feat[i]);
      acc = acc + sum_t'(exp_score[i]);          // wraps at the sum width
      if (rec_last[i]) begin
        exp_sum[grp] = acc;
        grp++;
        acc = '0;
      end
    end
  endtask

  // --------------------------------------------------
  // source, sink and monitor

  task automatic drive_source();
    int idx;
    int gap;
    idx = 0;
    gap = 0;
    while (idx < NUM_RECS) begin
      @(posedge clk);
      if (gap > 0) begin
        in_vld_i <= 1'b0;
        gap--;
      end else if (pushed - credit_rx < IN_DEPTH) begin
        in_vld_i  <= 1'b1;
        in_feat_i <= rec_feat[idx];
        in_last_i <= rec_last[idx];
        pushed++;
        idx++;
        gap = $urandom_range(0, 2);
      end else begin
        in_vld_i <= 1'b0;                        // out of credits, wait for a return
        stall_cycles++;
      end
    end
    @(posedge clk);
    in_vld_i <= 1'b0;
  endtask

  // the first output opens a phase without credit returns
  always @(posedge clk) begin
    out_credit_i <= 1'b0;
    if (!withhold_done && out_rx > 0) begin
      withhold_left = WITHHOLD_LEN;
      withhold_done = 1'b1;
    end
    if (withhold_left > 0) begin
      withhold_left--;
    end else if (out_rx > returned) begin
      out_credit_i <= 1'b1;
      returned++;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (in_credit_o) begin
        check_eq(32'(credit_rx < pushed), 32'd1, "credit returned for a record never pushed");
        credit_rx++;
      end
      if (out_vld_o) begin
        check_eq(32'(out_rx < NUM_GROUPS), 32'd1, "output beyond the last group");
        check_eq(32'(out_rx < OUT_CREDITS_INIT + returned), 32'd1, "output without sink credit");
        check_eq(32'(out_sum_o), 32'(exp_sum[out_rx]), "group sum");
        out_rx++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("TEST RESULT: FAIL");
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // --------------------------------------------------
  // main sequence

  initial begin
    logic [31:0] flags_exp;
    void'($urandom(1965));
    rst_n     = 1'b0;
    in_vld_i  = 1'b0;
    in_feat_i = '0;
    in_last_i = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(32'(out_vld_o), 32'd0, "out_vld_o after reset");
    check_eq(32'(in_credit_o), 32'd0, "in_credit_o after reset");
    check_eq(dbg_count_o, 32'd0, "dbg_count_o after reset");
    check_eq(dbg_capture_o, 32'd0, "dbg_capture_o after reset");
    check_eq(dbg_status_o, {BUILD_SIG[15:0], 16'h0000}, "dbg_status_o after reset");

    drive_source();
    while (out_rx != NUM_GROUPS) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("source stalled for %0d cycles", stall_cycles);

    flags_exp = {BUILD_SIG[15:0], 16'h0000};
    flags_exp[DBG_IN_PUSH]    = 1'b1;
    flags_exp[DBG_IN_POP]     = 1'b1;
    flags_exp[DBG_MID_PUSH]   = 1'b1;
    flags_exp[DBG_MID_POP]    = 1'b1;
    flags_exp[DBG_OUT_VLD]    = 1'b1;
    flags_exp[DBG_OUT_CREDIT] = 1'b1;
    check_eq(32'(credit_rx), 32'(NUM_RECS), "input credits returned");
    check_eq(dbg_count_o, 32'(NUM_RECS), "dbg_count_o at the end");
    check_eq(dbg_capture_o, 32'(exp_score[CAPTURE_IDX]), "dbg_capture_o at the end");
    check_eq(dbg_status_o, flags_exp, "dbg_status_o at the end");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* src/gat_top.sv */
`timescale 1ns/1ps

module gat_top
  import gat_cfg_pkg::*;
  import gat_dbg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_vld_i,
  input  feat_vec_t   in_feat_i,
  input  logic        in_last_i,
  output logic        in_credit_o,
  output logic        out_vld_o,
  output sum_t        out_sum_o,
  input  logic        out_credit_i,
  output logic [31:0] dbg_status_o,
  output logic [31:0] dbg_count_o,
  output logic [31:0] dbg_capture_o
);

  in_rec_t   in_head;
  logic      in_empty;
  logic      in_pop;
  feat_vec_t head_feat;
  logic      head_last;

  logic      dmvm_vld_in;
  logic      dmvm_vld;
  score_t    dmvm_score;
  logic      dmvm_last;

  mid_rec_t  mid_head;
  logic      mid_empty;
  logic      mid_pop;
  logic      mid_credit;
  score_t    mid_head_score;
  logic      mid_head_last;

  logic      aggr_acc;
  logic      aggr_emit;

  assign {head_last, head_feat}          = in_head;
  assign {mid_head_last, mid_head_score} = mid_head;

  // --------------------------------------------------
  // buffers

  credit_fifo #(
    .payload_t (in_rec_t),
    .DEPTH     (IN_DEPTH)
  ) in_fifo_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (in_vld_i),
    .push_data_i ({in_last_i, in_feat_i}),
    .pop_i       (in_pop),
    .pop_data_o  (in_head),
    .empty_o     (in_empty),
    .credit_o    (in_credit_o)
  );

  credit_fifo #(
    .payload_t (mid_rec_t),
    .DEPTH     (MID_DEPTH)
  ) mid_fifo_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (dmvm_vld),
    .push_data_i ({dmvm_last, dmvm_score}),
    .pop_i       (mid_pop),
    .pop_data_o  (mid_head),
    .empty_o     (mid_empty),
    .credit_o    (mid_credit)
  );

  // --------------------------------------------------
  // control and datapath

  gat_ctrl gat_ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_empty_i      (in_empty),
    .in_pop_o        (in_pop),
    .mid_credit_i    (mid_credit),
    .mid_empty_i     (mid_empty),
    .mid_head_last_i (mid_head_last),
    .mid_pop_o       (mid_pop),
    .dmvm_vld_o      (dmvm_vld_in),
    .aggr_acc_o      (aggr_acc),
    .aggr_emit_o     (aggr_emit),
    .out_credit_i    (out_credit_i)
  );

  dmvm_stage dmvm_stage_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_i   (dmvm_vld_in),
    .feat_i  (head_feat),
    .last_i  (head_last),
    .vld_o   (dmvm_vld),
    .score_o (dmvm_score),
    .last_o  (dmvm_last)
  );

  aggr_stage aggr_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_i     (aggr_acc),
    .emit_i    (aggr_emit),
    .score_i   (mid_head_score),
    .sum_vld_o (out_vld_o),
    .sum_o     (out_sum_o)
  );

  gat_debugger gat_debugger_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_push_i     (in_vld_i),
    .in_pop_i      (in_pop),
    .mid_push_i    (dmvm_vld),
    .mid_pop_i     (mid_pop),
    .out_vld_i     (out_vld_o),
    .out_credit_i  (out_credit_i),
    .score_vld_i   (dmvm_vld),
    .score_i       (dmvm_score),
    .dbg_status_o  (dbg_status_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

endmodule

/* src/gat_debugger.sv */
`timescale 1ns/1ps

module gat_debugger
  import gat_cfg_pkg::*;
  import gat_dbg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_push_i,
  input  logic        in_pop_i,
  input  logic        mid_push_i,
  input  logic        mid_pop_i,
  input  logic        out_vld_i,
  input  logic        out_credit_i,
  input  logic        score_vld_i,
  input  score_t      score_i,
  output logic [31:0] dbg_status_o,
  output logic [31:0] dbg_count_o,
  output logic [31:0] dbg_capture_o
);

  logic [DBG_NUM_FLAGS-1:0] evt;
  logic [DBG_NUM_FLAGS-1:0] flag;
  logic [DBG_NUM_FLAGS-1:0] flag_reg;
  logic [31:0]              count;
  logic [31:0]              count_reg;
  logic [31:0]              capture;
  logic [31:0]              capture_reg;

  assign evt[DBG_IN_PUSH]    = in_push_i;
  assign evt[DBG_IN_POP]     = in_pop_i;
  assign evt[DBG_MID_PUSH]   = mid_push_i;
  assign evt[DBG_MID_POP]    = mid_pop_i;
  assign evt[DBG_OUT_VLD]    = out_vld_i;
  assign evt[DBG_OUT_CREDIT] = out_credit_i;

  assign flag    = flag_reg | evt;                 // once seen a flag stays up until reset
  assign count   = score_vld_i ? (count_reg + 1'b1) : count_reg;
  assign capture = (score_vld_i && count_reg == 32'(CAPTURE_IDX)) ? 32'(score_i) : capture_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_reg    <= '0;
      count_reg   <= '0;
      capture_reg <= '0;
    end else begin
      flag_reg    <= flag;
      count_reg   <= count;
      capture_reg <= capture;
    end
  end

  assign dbg_status_o  = {BUILD_SIG[15:0], {(16 - DBG_NUM_FLAGS){1'b0}}, flag_reg};
  assign dbg_count_o   = count_reg;
  assign dbg_capture_o = capture_reg;

endmodule

/* aggr/aggr_stage.sv */
`timescale 1ns/1ps

module aggr_stage
  import gat_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   acc_i,
  input  logic   emit_i,
  input  score_t score_i,
  output logic   sum_vld_o,
  output sum_t   sum_o
);

  sum_t acc_q;
  sum_t acc_d;
  sum_t sum_q;
  logic sum_vld_q;

  // the closing score is folded in on the same cycle as the emit
  assign acc_d = acc_i ? (acc_q + sum_t'(score_i)) : acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q     <= '0;
      sum_vld_q <= 1'b0;
    end else begin
      acc_q     <= emit_i ? '0 : acc_d;          // next group starts from zero
      sum_vld_q <= emit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (emit_i) sum_q <= acc_d;
  end

  assign sum_vld_o = sum_vld_q;
  assign sum_o     = sum_q;

  // the control only closes a group while popping its last record
  a_emit_with_acc: assert property (@(posedge clk) disable iff (!rst_n)
    emit_i |-> acc_i);

endmodule

/* dmvm/dmvm_stage.sv */
`timescale 1ns/1ps

module dmvm_stage
  import gat_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      vld_i,
  input  feat_vec_t feat_i,
  input  logic      last_i,
  output logic      vld_o,
  output score_t    score_o,
  output logic      last_o
);

  logic signed [PROD_W-1:0] prod_q [VEC_LEN];
  score_t                   dot_d;
  score_t                   dot_q;
  score_t                   score_q;
  logic [DMVM_LAT-1:0]      vld_sr;
  logic [DMVM_LAT-1:0]      last_sr;

  // --------------------------------------------------
  // products, adder tree, leaky activation

  always_ff @(posedge clk) begin
    for (int k = 0; k < VEC_LEN; k++) begin
      prod_q[k] <= $signed(feat_i[k]) * $signed(ATT_WEIGHT[k]);
    end
  end

  always_comb begin
    dot_d = '0;
    for (int k = 0; k < VEC_LEN; k++) begin
      dot_d = dot_d + score_t'(prod_q[k]);        // sign-extended into the score width
    end
  end

  always_ff @(posedge clk) begin
    dot_q   <= dot_d;
    score_q <= dot_q[SCORE_W-1] ? (dot_q >>> LEAKY_SHIFT) : dot_q;
  end

  // --------------------------------------------------
  // valid and last travel beside the data

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[DMVM_LAT-2:0], vld_i};
    end
  end

  always_ff @(posedge clk) begin
    last_sr <= {last_sr[DMVM_LAT-2:0], last_i};
  end

  assign vld_o   = vld_sr[DMVM_LAT-1];
  assign last_o  = last_sr[DMVM_LAT-1];
  assign score_o = score_q;

endmodule

/* src/gat_ctrl.sv */
`timescale 1ns/1ps

module gat_ctrl
  import gat_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  input  logic in_empty_i,
  output logic in_pop_o,

  input  logic mid_credit_i,
  input  logic mid_empty_i,
  input  logic mid_head_last_i,
  output logic mid_pop_o,

  output logic dmvm_vld_o,
  output logic aggr_acc_o,
  output logic aggr_emit_o,

  input  logic out_credit_i
);

  localparam int MID_CNT_W = $clog2(MID_DEPTH + 1);
  localparam int OUT_CNT_W = $clog2(OUT_CREDITS_INIT + 1);

  logic [MID_CNT_W-1:0] mid_cnt;
  logic [OUT_CNT_W-1:0] out_cnt;
  logic                 mid_avail;
  logic                 out_avail;

  // --------------------------------------------------
  // issue decisions

  assign mid_avail = (mid_cnt != '0);
  assign out_avail = (out_cnt != '0);

  // a mid slot is reserved before the record enters the pipeline
  assign in_pop_o   = !in_empty_i && mid_avail;
  assign dmvm_vld_o = in_pop_o;

  // only a group close needs room at the sink
  assign mid_pop_o   = !mid_empty_i && (!mid_head_last_i || out_avail);
  assign aggr_acc_o  = mid_pop_o;
  assign aggr_emit_o = mid_pop_o && mid_head_last_i;

  // --------------------------------------------------
  // credit counters

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mid_cnt <= MID_CNT_W'(MID_DEPTH);
      out_cnt <= OUT_CNT_W'(OUT_CREDITS_INIT);   // sink grants its first credits silently
    end else begin
      mid_cnt <= mid_cnt + MID_CNT_W'(mid_credit_i) - MID_CNT_W'(in_pop_o);
      out_cnt <= out_cnt + OUT_CNT_W'(out_credit_i) - OUT_CNT_W'(aggr_emit_o);
    end
  end

  // more credits than slots means a buffer or the sink returned one twice
  // a count that drops below zero wraps to all ones and trips these too
  a_mid_bound: assert property (@(posedge clk) disable iff (!rst_n)
    mid_cnt <= MID_CNT_W'(MID_DEPTH));

  a_out_bound: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt <= OUT_CNT_W'(OUT_CREDITS_INIT));

endmodule

/* src/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo
  import gat_cfg_pkg::*;
#(
  parameter type payload_t = mid_rec_t,
  parameter int  DEPTH     = MID_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     empty_o,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             credit_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) wr_ptr <= ptr_next(wr_ptr);
      if (pop_i)  rd_ptr <= ptr_next(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_q <= pop_i;                           // one credit back per entry that leaves
    end
  end

  assign pop_data_o = mem[rd_ptr];
  assign empty_o    = (count == '0);
  assign credit_o   = credit_q;

  // the writer only pushes against a credit, so a full buffer never sees a push
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> (count != CNT_W'(DEPTH)));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

/* common/gat_dbg_pkg.sv */
package gat_dbg_pkg;

  // --------------------------------------------------
  // sticky flag positions in dbg_status_o

  localparam int DBG_IN_PUSH    = 0;
  localparam int DBG_IN_POP     = 1;
  localparam int DBG_MID_PUSH   = 2;
  localparam int DBG_MID_POP    = 3;
  localparam int DBG_OUT_VLD    = 4;
  localparam int DBG_OUT_CREDIT = 5;
  localparam int DBG_NUM_FLAGS  = 6;

  // --------------------------------------------------
  // capture point and signature

  localparam int CAPTURE_IDX = 5;                // zero-based arrival index of the score

  // only the low half shows up, in the upper half of dbg_status_o
  localparam logic [31:0] BUILD_SIG = 32'h47A7_5C0E;

endpackage

/* common/gat_cfg_pkg.sv */
package gat_cfg_pkg;

  // --------------------------------------------------
  // datapath widths and types

  localparam int FEAT_W  = 8;
  localparam int VEC_LEN = 4;
  localparam int PROD_W  = 2 * FEAT_W;
  localparam int SCORE_W = 18;
  localparam int SUM_W   = 24;                    // group sums wrap at this width

  typedef logic signed [FEAT_W-1:0]  feat_t;
  typedef feat_t       [VEC_LEN-1:0] feat_vec_t;
  typedef logic signed [SCORE_W-1:0] score_t;
  typedef logic signed [SUM_W-1:0]   sum_t;

  typedef logic [$bits(feat_vec_t):0] in_rec_t;  // last flag on top of the features
  typedef logic [SCORE_W:0]           mid_rec_t; // last flag on top of the score

  // --------------------------------------------------
  // attention weights, activation and credits

  localparam feat_vec_t ATT_WEIGHT = {feat_t'(1), feat_t'(5), feat_t'(-2), feat_t'(3)};
  localparam int LEAKY_SHIFT = 3;

  localparam int IN_DEPTH         = 4;
  localparam int MID_DEPTH        = 4;
  localparam int OUT_CREDITS_INIT = 2;
  localparam int DMVM_LAT         = 3;

endpackage
